// ==== source/isaPkg.sv ====
package isaPkg;

  ////////////////////////////////////////
  // Basic widths of the ISA
  ////////////////////////////////////////

  typedef logic [15:0] word_t;     // Data word, all ALU ops wrap here
  typedef logic [3:0]  regAddr_t;  // Index into 16 registers
  typedef logic [3:0]  opcode_t;   // Top nibble of instr
  typedef logic [15:0] instr_t;    // Raw instruction word

  // Instruction layout
  //   [15:12] opcode
  //   [11:8]  rd
  //   [7:4]   rs
  //   [3:0]   rt, doubles as shift amount
  //   [7:0]   immediate for LLB / LHB

  ////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////

  // Register-register arithmetic and logic
  localparam opcode_t OpAdd = 4'd0;
  localparam opcode_t OpSub = 4'd1;
  localparam opcode_t OpAnd = 4'd2;
  localparam opcode_t OpNor = 4'd3;

  // Shifts by rt field, not by rt register
  localparam opcode_t OpSll = 4'd4;
  localparam opcode_t OpSrl = 4'd5;
  localparam opcode_t OpSra = 4'd6;

  // Byte loads of the immediate
  localparam opcode_t OpLhb = 4'd10;  // High byte replaced, low kept
  localparam opcode_t OpLlb = 4'd11;  // Sign-extended imm

  localparam opcode_t OpHlt = 4'd15;  // Stops the core

  // Remaining codes decode as no-ops

endpackage

// ==== source/pipePkg.sv ====
package pipePkg;

  import isaPkg::*;

  ////////////////////////////////////////
  // Stage-to-stage bundles
  ////////////////////////////////////////

  // One retiring result, 21 bits
  // Shared by execute, result, regfile and the top output
  typedef struct packed {
    logic     valid;  // High only when a register is written
    regAddr_t addr;
    word_t    data;
  } writeBack_t;

  // Execute register contents, 22 bits
  typedef struct packed {
    writeBack_t wb;
    logic       halt;  // Valid HLT in flight
  } execOut_t;

  // Decode register contents, 59 bits
  typedef struct packed {
    logic       valid;   // Instruction accepted
    logic       writes;  // Gated by valid
    logic       halt;    // Gated by valid
    opcode_t    op;
    regAddr_t   rd;
    regAddr_t   rs;
    regAddr_t   rt;      // Also the shift amount
    word_t      srcA;    // Port A value at decode time
    word_t      srcB;    // Port B value at decode time
    logic [7:0] imm;
  } decoded_t;

endpackage

// ==== source/regFile.sv ====
`timescale 1ns/1ns

module regFile (
  input  logic                clk,
  input  logic                rstN,
  input  isaPkg::regAddr_t    rdAddrA,
  input  isaPkg::regAddr_t    rdAddrB,
  input  pipePkg::writeBack_t wr,
  output isaPkg::word_t       rdDataA,
  output isaPkg::word_t       rdDataB
);

  import isaPkg::*;

  word_t regs [0:15];  // Sixteen architectural registers

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstN) begin
      regs <= '{default: '0};  // All registers read zero after reset
    end else if (wr.valid) begin
      regs[wr.addr] <= wr.data;
    end
  end

  ////////////////////////////////////////
  // Read ports with bypass
  ////////////////////////////////////////

  // A write landing this edge is visible to the read in the same cycle,
  // which covers the producer three slots ahead
  assign rdDataA = (wr.valid && (wr.addr == rdAddrA)) ? wr.data : regs[rdAddrA];
  assign rdDataB = (wr.valid && (wr.addr == rdAddrB)) ? wr.data : regs[rdAddrB];

endmodule

// ==== source/decodeStage.sv ====
`timescale 1ns/1ns

module decodeStage (
  input  logic              clk,
  input  logic              rstN,
  input  logic              instrValid,
  input  isaPkg::instr_t    instr,
  input  isaPkg::word_t     rdDataA,
  input  isaPkg::word_t     rdDataB,
  output isaPkg::regAddr_t  rdAddrA,
  output isaPkg::regAddr_t  rdAddrB,
  output pipePkg::decoded_t dec
);

  import isaPkg::*;
  import pipePkg::*;

  opcode_t  op;
  regAddr_t rd;
  regAddr_t rs;
  regAddr_t rt;
  logic     writes;   // Opcode targets rd
  logic     isHalt;
  logic     accept;   // Strobe taken this cycle
  logic     halted;   // Sticky once HLT sampled
  decoded_t decNext;

  ////////////////////////////////////////
  // Field split and opcode decode
  ////////////////////////////////////////

  assign op = instr[15:12];
  assign rd = instr[11:8];
  assign rs = instr[7:4];
  assign rt = instr[3:0];

  assign writes = op inside {OpAdd, OpSub, OpAnd, OpNor,
                             OpSll, OpSrl, OpSra, OpLhb, OpLlb};
  assign isHalt = (op == OpHlt);

  // Nothing gets in after HLT
  assign accept = instrValid && !halted;

  // LHB merges into rd, so rd goes out on port A
  assign rdAddrA = (op == OpLhb) ? rd : rs;
  assign rdAddrB = rt;

  ////////////////////////////////////////
  // Decode register
  ////////////////////////////////////////

  always_comb begin
    decNext.valid  = accept;
    decNext.writes = accept && writes;  // No-ops and HLT write nothing
    decNext.halt   = accept && isHalt;
    decNext.op     = op;
    decNext.rd     = rd;
    decNext.rs     = rs;
    decNext.rt     = rt;
    decNext.srcA   = rdDataA;  // Regfile already bypassed
    decNext.srcB   = rdDataB;
    decNext.imm    = instr[7:0];
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      dec    <= '0;
      halted <= 1'b0;
    end else begin
      dec <= decNext;
      if (accept && isHalt) begin
        halted <= 1'b1;  // Held until reset
      end
    end
  end

endmodule

// ==== source/executeStage.sv ====
`timescale 1ns/1ns

module executeStage (
  input  logic                clk,
  input  logic                rstN,
  input  pipePkg::decoded_t   dec,
  input  pipePkg::writeBack_t resultFwd,
  output pipePkg::execOut_t   exOut
);

  import isaPkg::*;
  import pipePkg::*;

  regAddr_t srcAddrA;  // Register actually read on port A
  word_t    opA;
  word_t    opB;
  word_t    aluOut;
  execOut_t exNext;

  ////////////////////////////////////////
  // Forwarding
  ////////////////////////////////////////

  // Newest value wins, own register first, then result, then decode read
  function automatic word_t fwdSelect(input regAddr_t addr, input word_t regVal);
    word_t sel;
    if (exOut.wb.valid && (exOut.wb.addr == addr)) begin
      sel = exOut.wb.data;        // Distance 1
    end else if (resultFwd.valid && (resultFwd.addr == addr)) begin
      sel = resultFwd.data;       // Distance 2
    end else begin
      sel = regVal;               // Distance 3+ via regfile
    end
    return sel;
  endfunction

  assign srcAddrA = (dec.op == OpLhb) ? dec.rd : dec.rs;

  assign opA = fwdSelect(srcAddrA, dec.srcA);
  assign opB = fwdSelect(dec.rt, dec.srcB);

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    case (dec.op)
      OpAdd:   aluOut = opA + opB;  // Wraps at 16 bits
      OpSub:   aluOut = opA - opB;
      OpAnd:   aluOut = opA & opB;
      OpNor:   aluOut = ~(opA | opB);
      OpSll:   aluOut = opA << dec.rt;
      OpSrl:   aluOut = opA >> dec.rt;
      OpSra:   aluOut = word_t'($signed(opA) >>> dec.rt);  // Sign fills
      OpLhb:   aluOut = {dec.imm, opA[7:0]};               // Low byte of rd kept
      OpLlb:   aluOut = {{8{dec.imm[7]}}, dec.imm};
      default: aluOut = '0;  // No-op and HLT, never written
    endcase
  end

  ////////////////////////////////////////
  // Execute register
  ////////////////////////////////////////

  always_comb begin
    exNext.wb.valid = dec.valid && dec.writes;
    exNext.wb.addr  = dec.rd;
    exNext.wb.data  = aluOut;
    exNext.halt     = dec.valid && dec.halt;
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      exOut <= '0;
    end else begin
      exOut <= exNext;  // Also feeds back as forwarding source
    end
  end

endmodule

// ==== source/resultStage.sv ====
`timescale 1ns/1ns

module resultStage (
  input  logic                clk,
  input  logic                rstN,
  input  pipePkg::execOut_t   exOut,
  output pipePkg::writeBack_t wb,
  output logic                hlt
);

  ////////////////////////////////////////
  // Write-back register and halt
  ////////////////////////////////////////

  // wb goes three places at once
  //   regfile write port, absorbed next edge
  //   second forwarding source in execute
  //   top-level retire output
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wb  <= '0;
      hlt <= 1'b0;
    end else begin
      wb <= exOut.wb;
      if (exOut.halt) begin
        hlt <= 1'b1;  // Sticky until reset
      end
    end
  end

  // Anything issued before HLT is already ahead of it,
  // so every older write-back retires no later than hlt rises

endmodule

// ==== source/cpuCore.sv ====
`timescale 1ns/1ns

module cpuCore (
  input  logic                clk,
  input  logic                rstN,
  input  logic                instrValid,
  input  isaPkg::instr_t      instr,
  output pipePkg::writeBack_t wb,
  output logic                hlt
);

  import isaPkg::*;
  import pipePkg::*;

  regAddr_t rdAddrA;
  regAddr_t rdAddrB;
  word_t    rdDataA;
  word_t    rdDataB;
  decoded_t dec;    // Decode to execute
  execOut_t exOut;  // Execute to result

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////

  regFile regFile0 (
    .clk     (clk),
    .rstN    (rstN),
    .rdAddrA (rdAddrA),
    .rdAddrB (rdAddrB),
    .wr      (wb),       // Retired result writes back
    .rdDataA (rdDataA),
    .rdDataB (rdDataB)
  );

  decodeStage decode0 (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .instr      (instr),
    .rdDataA    (rdDataA),
    .rdDataB    (rdDataB),
    .rdAddrA    (rdAddrA),
    .rdAddrB    (rdAddrB),
    .dec        (dec)
  );

  executeStage execute0 (
    .clk       (clk),
    .rstN      (rstN),
    .dec       (dec),
    .resultFwd (wb),     // Second forwarding source
    .exOut     (exOut)
  );

  resultStage result0 (
    .clk   (clk),
    .rstN  (rstN),
    .exOut (exOut),
    .wb    (wb),
    .hlt   (hlt)
  );

endmodule

// ==== tb/cpuCore_props.sv ====
`timescale 1ns/1ns

module cpuCoreProps (
  input logic                clk,
  input logic                rstN,
  input pipePkg::writeBack_t wb,
  input logic                hlt
);

  // Sync reset, cleared value shows one edge later
  noWbInReset: assert property (@(posedge clk) !rstN |=> !wb.valid)
    else $error("wb.valid high during reset");

  hltSticky: assert property (@(posedge clk) disable iff (!rstN) hlt |=> hlt)
    else $error("hlt fell while reset was inactive");

  // Once halt has been up a full cycle nothing else retires
  quietAfterHalt: assert property (
    @(posedge clk) disable iff (!rstN) hlt && $past(hlt) |-> !wb.valid)
    else $error("write-back after hlt rose");

endmodule

// ==== tb/cpuCoreTb.sv ====
`timescale 1ns/1ns

module cpuCoreTb;

  import isaPkg::*;
  import pipePkg::*;

  localparam int StreamLen = 60;
  // Upper bound on cycles, resets and drains included
  localparam int TotalCycles = 2 * 9 + 12 + 16 + 7 * StreamLen + 6 * 8;

  logic        clk;
  logic        rstN;
  logic        instrValid;
  instr_t      instr;
  writeBack_t  wb;
  logic        hlt;
  logic [31:0] seed = 32'h47e3_ac67;
  word_t       model [0:15];  // Register state in issue order
  logic        modelHalted;
  writeBack_t  expQ [$];      // Expected retirements, oldest first
  string       testName;
  int          errors;
  int          errAtStart;
  int          checks;
  int          tests;

  cpuCore dut0 (.*);
  bind cpuCore cpuCoreProps props0 (.clk(clk), .rstN(rstN), .wb(wb), .hlt(hlt));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // Random numbers and reference model
  ////////////////////////////////////////

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;  // LCG, use upper bits only
    return seed;
  endfunction

  // Class 0 plain ALU, 1 shifts and byte loads, 2 any kept op, 3 no-ops
  function automatic opcode_t pickOp(input int kind, input int r);
    int k;
    if (kind == 3) begin
      k = r % 6;
      return opcode_t'((k < 3) ? 7 + k : 9 + k);  // 7..9, 12..14
    end
    k = (kind == 0) ? r % 4 : (kind == 1) ? 4 + r % 5 : r % 9;
    return opcode_t'((k < 7) ? k : k + 3);  // Slots 7, 8 are LHB, LLB
  endfunction

  function automatic instr_t randInstr(input int kind);
    logic [31:0] r;
    logic [31:0] f;
    opcode_t     op;
    regAddr_t    rt;
    r  = nextRand();
    f  = nextRand();
    op = pickOp(kind, int'(r[30:20]));
    rt = (kind == 1) ? f[23:20] : {2'b00, f[21:20]};  // Full shift range in class 1
    if (kind == 0) begin
      return {op, 1'b0, f[18:16], 1'b1, f[21:19], 1'b1, f[24:22]};  // rd low, sources high
    end
    if (op inside {OpLhb, OpLlb}) begin
      return {op, 2'b00, f[17:16], f[31:24]};
    end
    return {op, 2'b00, f[17:16], 2'b00, f[19:18], rt};  // Four registers, many hazards
  endfunction

  function automatic writeBack_t modelExec(input instr_t ins);
    writeBack_t res;
    word_t      a;
    word_t      b;
    a         = model[ins[7:4]];
    b         = model[ins[3:0]];
    res.valid = 1'b1;
    res.addr  = ins[11:8];
    case (ins[15:12])
      OpAdd: res.data = a + b;
      OpSub: res.data = a + ~b + 16'd1;  // Two's complement
      OpAnd: res.data = a & b;
      OpNor: res.data = ~a & ~b;
      OpSll: res.data = a << ins[3:0];
      OpSrl: res.data = a >> ins[3:0];
      // Vacated top bits copy the sign
      OpSra: res.data = (a >> ins[3:0]) | ({16{a[15]}} & ~(16'hffff >> ins[3:0]));
      OpLhb: res.data = {ins[7:0], model[ins[11:8]][7:0]};
      OpLlb: res.data = word_t'($signed(ins[7:0]));
      default: begin
        res.valid = 1'b0;  // No-op
        res.data  = '0;
      end
    endcase
    return res;
  endfunction

  ////////////////////////////////////////
  // Stimulus and checks
  ////////////////////////////////////////

  task automatic issue(input logic v, input instr_t ins);
    writeBack_t res;
    @(posedge clk);
    instrValid <= v;
    instr      <= ins;
    if (v && !modelHalted) begin
      if (ins[15:12] == OpHlt) begin
        modelHalted = 1'b1;  // Later strobes ignored
      end else begin
        res = modelExec(ins);
        if (res.valid) begin
          model[res.addr] = res.data;
          expQ.push_back(res);
        end
      end
    end
  endtask

  task automatic stream(input int kind, input int n);
    logic [31:0] r;
    repeat (n) begin
      r = nextRand();
      issue(r[31:30] != 2'b00, randInstr(kind));  // Strobe on about 3 of 4 cycles
    end
  endtask

  task automatic drain();
    while (expQ.size() != 0) begin
      issue(1'b0, '0);
    end
    repeat (4) issue(1'b0, '0);  // Room for stray write-backs
  endtask

  task automatic applyReset();
    @(posedge clk);
    rstN       <= 1'b0;
    instrValid <= 1'b0;
    repeat (8) @(posedge clk);
    rstN       <= 1'b1;
    model       = '{default: '0};
    modelHalted = 1'b0;
    expQ.delete();
  endtask

  task automatic checkWb(input writeBack_t exp, input writeBack_t act);
    checks++;
    if (act.addr !== exp.addr || act.data !== exp.data) begin
      $display("CHECK FAILED %s expected r%0d=%h actual r%0d=%h",
               testName, exp.addr, exp.data, act.addr, act.data);
      errors++;
    end
  endtask

  task automatic checkHalt(input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("CHECK FAILED %s expected hlt=%b actual hlt=%b", testName, exp, act);
      errors++;
    end
  endtask

  task automatic beginTest(input string name);
    testName   = name;
    errAtStart = errors;
  endtask

  task automatic endTest();
    tests++;
    if (errors == errAtStart) begin
      $display("test %s: ok", testName);
    end else begin
      $display("test %s: %0d errors", testName, errors - errAtStart);
    end
  endtask

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    if (rstN && wb.valid) begin
      if (expQ.size() == 0) begin
        $display("%s: write-back to r%0d that no instruction should make", testName, wb.addr);
        errors++;
      end else begin
        checkWb(expQ.pop_front(), wb);
      end
    end
    if (rstN && hlt && expQ.size() != 0) begin
      $display("%s: halt raised with %0d results not retired", testName, expQ.size());
      errors++;
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic [31:0] r;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    applyReset();

    beginTest("reset idle");
    repeat (10) issue(1'b0, '0);
    @(negedge clk);
    checkHalt(1'b0, hlt);
    endTest();

    beginTest("alu independent");
    for (int i = 8; i < 16; i++) begin
      r = nextRand();
      issue(1'b1, {OpLlb, 4'(i), r[31:24]});  // Seed the source registers
      issue(1'b1, {OpLhb, 4'(i), r[23:16]});
    end
    stream(0, StreamLen);
    drain();
    endTest();

    beginTest("shift and byte load");
    stream(1, StreamLen);
    drain();
    endTest();

    beginTest("dependent chains");
    stream(2, 2 * StreamLen);
    drain();
    endTest();

    beginTest("no-op mix");
    repeat (4) begin
      stream(3, 10);
      stream(2, 5);
    end
    drain();
    endTest();

    beginTest("halt");
    stream(2, 20);
    issue(1'b1, {OpHlt, 12'h000});
    stream(2, 20);  // All dropped by the core
    drain();
    @(negedge clk);
    checkHalt(1'b1, hlt);
    applyReset();
    @(negedge clk);
    checkHalt(1'b0, hlt);
    issue(1'b1, {OpAdd, 4'd1, 4'd2, 4'd3});  // Zero after reset
    drain();
    endTest();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #((TotalCycles + 50) * 20);
    $display("Watchdog expired in test %s before the run finished", testName);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
source/isaPkg.sv
source/pipePkg.sv
source/regFile.sv
source/decodeStage.sv
source/executeStage.sv
source/resultStage.sv
source/cpuCore.sv
tb/cpuCore_props.sv
tb/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module cpuCoreTb -f filelist.f -o cpuCoreSim \
  && ./obj_dir/cpuCoreSim > sim.log 2>&1 \
  && grep -q "Simulation passed" sim.log \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
